// File: list.f
+incdir+hdl
hdl/sum_kernel_pkg.sv
hdl/edge_stream_if.sv
hdl/sync_fifo.sv
hdl/edge_fetch.sv
hdl/edge_accumulate.sv
hdl/result_writeback.sv
hdl/sum_kernel_top.sv
verification/sum_kernel_asserts.sv
verification/sum_kernel_tb.sv

// File: Bender.yml
package:
  name: sum_kernel

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/sum_kernel_pkg.sv
      - hdl/edge_stream_if.sv
      - hdl/sync_fifo.sv
      - hdl/edge_fetch.sv
      - hdl/edge_accumulate.sv
      - hdl/result_writeback.sv
      - hdl/sum_kernel_top.sv
  - target: simulation
    files:
      - verification/sum_kernel_asserts.sv
      - verification/sum_kernel_tb.sv

// File: verification/sum_kernel_tb.sv
// Sum kernel testbench

module sum_kernel_tb import sum_kernel_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam cu_id_t CU_ID = 8'h5a;
	localparam int NV_SUM = 16;
	localparam int NV_BP = 12;
	localparam int NV_ALL = NV_SUM + NV_BP + 2;

	logic clock;
	logic rstn;
	logic enabled_in;
	logic data_empty;
	logic edge_valid;
	edge_data_t edge_data;
	logic vertex_valid;
	vertex_id_t vertex_id;
	count_t vertex_degree;
	logic write_bus_grant;
	logic write_buffer_alfull;
	logic write_response_valid;
	logic edge_request;
	logic write_bus_request;
	logic result_valid;
	edge_data_t result_sum;
	vertex_id_t result_index;
	cu_id_t result_cu_id;
	count_t edge_count;
	count_t response_count;

	// Upstream buffer and reply line
	edge_data_t source_q[$];
	edge_data_t reply_q[$];
	int reply_due_q[$];
	int up_cycle;
	int last_due;
	int due;

	// Bus model state
	logic hold_grants;
	int stall_cnt;
	int stall_target;
	int resp_due_q[$];
	int bus_cycle;
	int response_pulses;

	// Scoreboard
	edge_data_t exp_sum_q[$];
	vertex_id_t exp_index_q[$];
	edge_data_t exp_sum;
	vertex_id_t exp_index;
	count_t total_edges;

	int degrees[NV_ALL];
	int errors;
	int tests_run;
	int tests_failed;
	int cycle_count;
	int cycle_limit;
	int block_run;
	logic block_seen;

	sum_kernel_top #(
		.CU_ID(CU_ID)
	) i_sum_kernel_top (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// Upstream model
	////////////////////

	// One reply per claimed request 1 to 3 cycles later and at most one per cycle
	always @(posedge clock) begin
		up_cycle++;
		if (edge_request && source_q.size() > 0) begin
			due = up_cycle + $urandom_range(1, 3);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			reply_q.push_back(source_q.pop_front());
			reply_due_q.push_back(due);
		end
		if (reply_q.size() > 0 && reply_due_q[0] <= up_cycle) begin
			void'(reply_due_q.pop_front());
			edge_valid <= 1'b1;
			edge_data <= reply_q.pop_front();
		end else begin
			edge_valid <= 1'b0;
		end
		data_empty <= (source_q.size() == 0);
	end

	////////////////////
	// Bus model
	////////////////////

	always @(posedge clock) begin
		bus_cycle++;
		write_bus_grant <= 1'b0;
		if (write_bus_request && !write_bus_grant && !hold_grants) begin
			if (stall_cnt >= stall_target) begin
				write_bus_grant <= 1'b1;
				stall_cnt = 0;
				stall_target = $urandom_range(0, 4);
			end else begin
				stall_cnt++;
			end
		end
		// Write completes a few cycles after the result
		if (rstn && result_valid) begin
			resp_due_q.push_back(bus_cycle + 3);
		end
		write_response_valid <= 1'b0;
		if (resp_due_q.size() > 0 && resp_due_q[0] <= bus_cycle) begin
			void'(resp_due_q.pop_front());
			write_response_valid <= 1'b1;
			response_pulses++;
		end
	end

	// Results against the scoreboard in job order
	always @(posedge clock) begin
		if (rstn && result_valid) begin
			if (exp_sum_q.size() == 0) begin
				$display("Unexpected result at %0t with no vertex pending", $time);
				errors++;
			end else begin
				exp_sum = exp_sum_q.pop_front();
				exp_index = exp_index_q.pop_front();
				assert (result_sum == exp_sum && result_index == exp_index
					&& result_cu_id == CU_ID)
				else begin
					$display("MISMATCH %0t: result %h/%h/%h, expected %h/%h/%h", $time,
						result_sum, result_index, result_cu_id, exp_sum, exp_index, CU_ID);
					errors++;
				end
			end
		end
	end

	// Upstream holds data but no edge is asked for
	always @(posedge clock) begin
		if (rstn && enabled_in && !data_empty && !edge_request) begin
			block_run++;
		end else begin
			block_run = 0;
		end
		if (block_run >= 4) begin
			block_seen = 1'b1;
		end
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Run stopped: cycle limit of %0d reached before the tests ended",
				cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////
	// Tasks
	////////////////////

	// Load a vertex job and its edges and record the expected result
	task automatic start_vertex(input int v);
		edge_data_t sum;
		edge_data_t value;
		sum = '0;
		@(posedge clock);
		for (int i = 0; i < degrees[v]; i++) begin
			value = $urandom();
			sum = sum + value;
			source_q.push_back(value);
		end
		vertex_valid <= 1'b1;
		vertex_id <= vertex_id_t'(16'h0100 + v);
		vertex_degree <= count_t'(degrees[v]);
		exp_sum_q.push_back(sum);
		exp_index_q.push_back(vertex_id_t'(16'h0100 + v));
		total_edges = total_edges + count_t'(degrees[v]);
	endtask

	// Wait for every edge and confirm the count settles
	task automatic finish_vertex();
		while (edge_count != total_edges) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
		assert (edge_count == total_edges)
		else begin
			$display("MISMATCH %0t: edge_count %0d, expected %0d", $time,
				edge_count, total_edges);
			errors++;
		end
	endtask

	// Let every result leave and every write complete
	task automatic drain_results();
		while (exp_sum_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (10) @(posedge clock);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %0s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %0s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		int e0;
		int hold_wait;
		count_t ec_hold;
		count_t rc_hold;
		void'($urandom(32'hb78f_824a));
		rstn = 1'b0;
		enabled_in = 1'b1;
		data_empty = 1'b1;
		edge_valid = 1'b0;
		edge_data = '0;
		vertex_valid = 1'b0;
		vertex_id = '0;
		vertex_degree = '0;
		write_bus_grant = 1'b0;
		write_buffer_alfull = 1'b0;
		write_response_valid = 1'b0;
		hold_grants = 1'b0;
		block_seen = 1'b0;
		stall_target = 1;
		total_edges = '0;
		cycle_limit = 2000;
		for (int v = 0; v < NV_ALL; v++) begin
			degrees[v] = $urandom_range(1, 8);
			cycle_limit += 20 * degrees[v];
		end

		// Reset values
		e0 = errors;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		assert (!edge_request && !write_bus_request && !result_valid
			&& edge_count == '0 && response_count == '0)
		else begin
			$display("MISMATCH %0t: strobes or counters not zero after reset", $time);
			errors++;
		end
		report_test("reset", e0);

		// Sums and edge counting
		e0 = errors;
		for (int v = 0; v < NV_SUM; v++) begin
			start_vertex(v);
			finish_vertex();
		end
		drain_results();
		report_test("sums", e0);

		// Grants withheld across many vertices
		e0 = errors;
		fork
			begin
				for (int v = NV_SUM; v < NV_SUM + NV_BP; v++) begin
					start_vertex(v);
					finish_vertex();
				end
			end
			begin
				@(posedge clock);
				hold_grants <= 1'b1;
				block_seen = 1'b0;
				hold_wait = 0;
				while (!block_seen && hold_wait < 400) begin
					@(posedge clock);
					hold_wait++;
				end
				repeat (40) @(posedge clock);
				if (!block_seen) begin
					$display("edge_request never fell while grants were withheld");
					errors++;
				end
				// Full write buffer drops the bus request before grants resume
				write_buffer_alfull <= 1'b1;
				repeat (2) @(posedge clock);
				hold_grants <= 1'b0;
				repeat (10) @(posedge clock);
				write_buffer_alfull <= 1'b0;
			end
		join
		drain_results();
		report_test("back-pressure", e0);

		// Write responses
		e0 = errors;
		assert (response_count == count_t'(response_pulses))
		else begin
			$display("MISMATCH %0t: response_count %0d, expected %0d", $time,
				response_count, response_pulses);
			errors++;
		end
		report_test("responses", e0);

		// Disabled unit holds everything while a result waits in the FIFO
		e0 = errors;
		hold_grants <= 1'b1;
		start_vertex(NV_ALL - 2);
		finish_vertex();
		repeat (2) @(posedge clock);
		enabled_in <= 1'b0;
		repeat (3) @(posedge clock);
		hold_grants <= 1'b0;
		ec_hold = edge_count;
		rc_hold = response_count;
		// Write response arriving while disabled
		resp_due_q.push_back(bus_cycle + 2);
		start_vertex(NV_ALL - 1);
		repeat (20) begin
			@(posedge clock);
			assert (!edge_request && !write_bus_request && !result_valid
				&& edge_count == ec_hold && response_count == rc_hold)
			else begin
				$display("MISMATCH %0t: strobe or counter moved while disabled", $time);
				errors++;
			end
		end
		enabled_in <= 1'b1;
		finish_vertex();
		drain_results();
		report_test("enable", e0);

		errors += i_sum_kernel_top.i_sum_kernel_asserts.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run,
			tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: verification/sum_kernel_asserts.sv
// Sum kernel protocol assertions

module sum_kernel_asserts (
	input logic clock,
	input logic rstn,
	input logic data_empty,
	input logic edge_request,
	input logic write_buffer_alfull,
	input logic write_bus_request,
	input logic write_bus_grant,
	input logic result_valid
);

	timeunit 1ns;
	timeprecision 1ns;

	// Count of failed assertions
	int fail_count = 0;

	////////////////////
	// Request rules
	////////////////////

	// Empty upstream seen twice in a row stops the edge request
	edge_request_after_empty: assert property (@(posedge clock) disable iff (!rstn)
		(data_empty && $past(data_empty)) |=> !edge_request)
	else begin
		$error("edge_request high after two empty cycles upstream");
		fail_count++;
	end

	// Full write buffer seen twice in a row stops the bus request
	bus_request_after_alfull: assert property (@(posedge clock) disable iff (!rstn)
		(write_buffer_alfull && $past(write_buffer_alfull)) |=> !write_bus_request)
	else begin
		$error("write_bus_request high after two almost-full cycles");
		fail_count++;
	end

	////////////////////
	// Grant timing
	////////////////////

	// Result two cycles after each grant
	result_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		write_bus_grant |-> ##2 result_valid)
	else begin
		$error("no result_valid two cycles after a grant");
		fail_count++;
	end

	// And never without one
	result_needs_grant: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |-> $past(write_bus_grant, 2))
	else begin
		$error("result_valid without a grant two cycles before");
		fail_count++;
	end

endmodule

bind sum_kernel_top sum_kernel_asserts i_sum_kernel_asserts (.*);

// File: hdl/sum_kernel_top.sv
// Sum kernel compute unit

module sum_kernel_top import sum_kernel_pkg::*; #(
	parameter cu_id_t CU_ID = 8'd1
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled_in,
	// Upstream edge buffer
	input  logic       data_empty,
	input  logic       edge_valid,
	input  edge_data_t edge_data,
	// Vertex job
	input  logic       vertex_valid,
	input  vertex_id_t vertex_id,
	input  count_t     vertex_degree,
	// Shared write bus
	input  logic       write_bus_grant,
	input  logic       write_buffer_alfull,
	input  logic       write_response_valid,
	output logic       edge_request,
	output logic       write_bus_request,
	output logic       result_valid,
	output edge_data_t result_sum,
	output vertex_id_t result_index,
	output cu_id_t     result_cu_id,
	// Progress counters
	output count_t     edge_count,
	output count_t     response_count
);

	edge_stream_if stream_if ();

	logic       push;
	edge_data_t push_sum;
	vertex_id_t push_index;
	logic       result_alfull;

	////////////////////
	// Stages
	////////////////////

	edge_fetch i_edge_fetch (
		.clock       (clock),
		.rstn        (rstn),
		.enabled_in  (enabled_in),
		.data_empty  (data_empty),
		.edge_valid  (edge_valid),
		.edge_data   (edge_data),
		.edge_request(edge_request),
		.stream      (stream_if.fetch)
	);

	edge_accumulate i_edge_accumulate (
		.clock        (clock),
		.rstn         (rstn),
		.stream       (stream_if.accumulate),
		.vertex_valid (vertex_valid),
		.vertex_id    (vertex_id),
		.vertex_degree(vertex_degree),
		.result_alfull(result_alfull),
		.push         (push),
		.push_sum     (push_sum),
		.push_index   (push_index),
		.edge_count   (edge_count)
	);

	// Writeback runs on the enable latched in fetch
	result_writeback #(
		.CU_ID(CU_ID)
	) i_result_writeback (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (stream_if.enabled),
		.push                (push),
		.push_sum            (push_sum),
		.push_index          (push_index),
		.write_bus_grant     (write_bus_grant),
		.write_buffer_alfull (write_buffer_alfull),
		.write_response_valid(write_response_valid),
		.result_alfull       (result_alfull),
		.write_bus_request   (write_bus_request),
		.result_valid        (result_valid),
		.result_sum          (result_sum),
		.result_index        (result_index),
		.result_cu_id        (result_cu_id),
		.response_count      (response_count)
	);

endmodule

// File: hdl/result_writeback.sv
// Result buffering and write bus handshake

`include "sum_kernel_macros.svh"

module result_writeback import sum_kernel_pkg::*; #(
	parameter cu_id_t CU_ID = 8'd1
) (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled,
	input  logic       push,
	input  edge_data_t push_sum,
	input  vertex_id_t push_index,
	input  logic       write_bus_grant,
	input  logic       write_buffer_alfull,
	input  logic       write_response_valid,
	output logic       result_alfull,
	output logic       write_bus_request,
	output logic       result_valid,
	output edge_data_t result_sum,
	output vertex_id_t result_index,
	output cu_id_t     result_cu_id,
	output count_t     response_count
);

	localparam int ENTRY_W = $bits(edge_data_t) + $bits(vertex_id_t);

	logic [ENTRY_W-1:0] fifo_out;
	logic               fifo_empty;
	logic               grant_latched;
	logic               pop;

	// Sum and index kept together per entry
	sync_fifo #(
		.WIDTH(ENTRY_W),
		.DEPTH(`SK_RESULT_DEPTH)
	) i_result_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.data_in ({push_sum, push_index}),
		.pop     (pop),
		.data_out(fifo_out),
		.empty   (fifo_empty),
		.full    (),
		.alfull  (result_alfull)
	);

	// One entry leaves per latched grant
	assign pop = enabled && grant_latched && !fifo_empty;

	////////////////////
	// Bus handshake
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_latched     <= 1'b0;
			write_bus_request <= 1'b0;
			result_valid      <= 1'b0;
			response_count    <= '0;
		end else if (enabled) begin
			grant_latched     <= write_bus_grant;
			// Held off while a grant is still on its way to the pop
			write_bus_request <= !fifo_empty && !write_buffer_alfull
				&& !write_bus_grant && !grant_latched;
			result_valid      <= pop;
			if (write_response_valid) begin
				response_count <= response_count + 1'b1;
			end
		end else begin
			write_bus_request <= 1'b0;
			result_valid      <= 1'b0;
		end
	end

	// Popped entry out the cycle after the pop
	always_ff @(posedge clock) begin
		if (pop) begin
			{result_sum, result_index} <= fifo_out;
			result_cu_id               <= CU_ID;
		end
	end

endmodule

// File: hdl/edge_accumulate.sv
// Per-vertex edge accumulation

module edge_accumulate import sum_kernel_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	edge_stream_if.accumulate stream,
	input  logic       vertex_valid,
	input  vertex_id_t vertex_id,
	input  count_t     vertex_degree,
	input  logic       result_alfull,
	output logic       push,
	output edge_data_t push_sum,
	output vertex_id_t push_index,
	output count_t     edge_count
);

	accum_state_t state;
	edge_data_t   sum;
	count_t       vertex_count;
	logic         job_valid;
	vertex_id_t   job_id;
	count_t       job_degree;
	logic         job_done;
	logic         job_complete;

	// Result space back to fetch
	assign stream.request_block = result_alfull;

	////////////////////
	// Vertex job latch
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid <= 1'b0;
			job_done  <= 1'b0;
		end else if (stream.enabled) begin
			job_valid <= vertex_valid;
			// Emitted job stays spent until a different job shows up
			if (state == accum_summing && job_complete) begin
				job_done <= 1'b1;
			end else if (!vertex_valid || vertex_id != job_id || vertex_degree != job_degree) begin
				job_done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (stream.enabled) begin
			job_id     <= vertex_id;
			job_degree <= vertex_degree;
		end
	end

	// All edges of the current job summed
	assign job_complete = job_valid && !job_done && (vertex_count == job_degree);

	////////////////////
	// Summing FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= accum_idle;
			sum          <= '0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else if (stream.enabled) begin
			// Running total over all vertices
			if (stream.valid) begin
				edge_count <= edge_count + 1'b1;
			end
			case (state)
				accum_idle: begin
					if (stream.valid) begin
						sum          <= stream.data;
						vertex_count <= count_t'(1);
						state        <= accum_summing;
					end
				end
				accum_summing: begin
					if (job_complete) begin
						// Next vertex may start in the same cycle
						sum          <= stream.valid ? stream.data : '0;
						vertex_count <= stream.valid ? count_t'(1) : '0;
						state        <= accum_emit;
					end else if (stream.valid) begin
						sum          <= sum + stream.data;
						vertex_count <= vertex_count + 1'b1;
					end
				end
				default: begin
					if (stream.valid) begin
						sum          <= sum + stream.data;
						vertex_count <= vertex_count + 1'b1;
					end
					state <= (stream.valid || vertex_count != '0) ? accum_summing : accum_idle;
				end
			endcase
		end
	end

	// Result captured on the way into emit
	always_ff @(posedge clock) begin
		if (stream.enabled && state == accum_summing && job_complete) begin
			push_sum   <= sum;
			push_index <= job_id;
		end
	end

	// One push per emit cycle
	assign push = (state == accum_emit) && stream.enabled;

endmodule

// File: hdl/edge_fetch.sv
// Edge fetch stage

module edge_fetch import sum_kernel_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled_in,
	input  logic       data_empty,
	input  logic       edge_valid,
	input  edge_data_t edge_data,
	output logic       edge_request,
	edge_stream_if.fetch stream
);

	logic enabled;
	logic empty_latched;

	////////////////////
	// Enable latch
	////////////////////

	// Enable change acts one cycle later
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// Later stages follow the same enable
	assign stream.enabled = enabled;

	////////////////////
	// Edge request
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// Upstream treated as empty until seen
			empty_latched <= 1'b1;
			edge_request  <= 1'b0;
		end else if (enabled) begin
			empty_latched <= data_empty;
			// One edge asked per cycle while upstream has data and results fit
			edge_request  <= !empty_latched && !stream.request_block;
		end else begin
			// No strobe while disabled
			edge_request  <= 1'b0;
		end
	end

	////////////////////
	// Edge input register
	////////////////////

	// Valid follows the upstream strobe, cleared in cycles without an edge
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stream.valid <= 1'b0;
		end else if (enabled) begin
			stream.valid <= edge_valid;
		end
	end

	// Value only captured with its strobe
	always_ff @(posedge clock) begin
		if (enabled && edge_valid) begin
			stream.data <= edge_data;
		end
	end

endmodule

// File: hdl/sync_fifo.sv
// Show-ahead synchronous FIFO

`include "sum_kernel_macros.svh"

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Occupancy flags
	assign empty  = (count == '0);
	assign full   = (count == CNT_W'(DEPTH));
	assign alfull = (CNT_W'(DEPTH) - count) <= CNT_W'(`SK_ALFULL_SLACK);

	// Pop only real data, push into a full buffer only alongside a pop
	assign do_pop  = pop && !empty;
	assign do_push = push && (!full || do_pop);

	// Head entry always visible
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keeps the count
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/edge_stream_if.sv
// Edge stream from fetch to accumulate

interface edge_stream_if import sum_kernel_pkg::*; ();

	// Latched edge strobe and value
	logic       valid;
	edge_data_t data;

	// Registered unit enable, shared by the later stages
	logic       enabled;

	// Result space low, stops new edge requests
	logic       request_block;

	// Producer side
	modport fetch (
		output valid,
		output data,
		output enabled,
		input  request_block
	);

	// Consumer side
	modport accumulate (
		input  valid,
		input  data,
		input  enabled,
		output request_block
	);

endinterface

// File: hdl/sum_kernel_pkg.sv
// Sum kernel types

`include "sum_kernel_macros.svh"

package sum_kernel_pkg;

	////////////////////
	// Vector types
	////////////////////

	// Edge value or running sum
	typedef logic [`SK_DATA_W-1:0] edge_data_t;

	// Vertex index
	typedef logic [`SK_VERTEX_W-1:0] vertex_id_t;

	// Degree or event counter
	typedef logic [`SK_COUNT_W-1:0] count_t;

	// Compute unit id stamped on results
	typedef logic [7:0] cu_id_t;

	////////////////////
	// Accumulate FSM
	////////////////////

	// Idle until the first edge of a vertex
	// Summing until the degree is reached
	// Emit for one push cycle
	typedef enum logic [1:0] {
		accum_idle,
		accum_summing,
		accum_emit
	} accum_state_t;

endpackage

// File: hdl/sum_kernel_macros.svh
// Sum kernel sizing macros

`ifndef SUM_KERNEL_MACROS_SVH
`define SUM_KERNEL_MACROS_SVH

////////////////////
// Datapath widths
////////////////////

// Edge value and vertex sum
`define SK_DATA_W 32

// Vertex index
`define SK_VERTEX_W 16

// Degree, edge counter and response counter
`define SK_COUNT_W 32

////////////////////
// Result buffering
////////////////////

// Entries in the result FIFO
`define SK_RESULT_DEPTH 8

// Free entries left when almost full is raised
// Leaves room for edges already requested upstream
`define SK_ALFULL_SLACK 3

`endif
